//--- rtl/core_pkg.sv
// shared widths and constants for the core glue logic
// bridge region code, hsync delay and counter type
// controller key word union, raw and per-button views

package core_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // bridge address and data words
  localparam int bridge_w = 32;

  // packed colour, r in the top byte
  localparam int rgb_w = 24;

  // controller key bitmap from the host
  localparam int key_w = 16;

  // nes joypad shift register byte
  localparam int nes_btn_w = 8;

  ////////////////////////////////////////
  // bridge
  ////////////////////////////////////////

  // top address byte of the command region
  localparam logic [7:0] bridge_region_cmd = 8'hF8;

  // download flag position in the status word
  localparam int status_dl_bit = 8;

  ////////////////////////////////////////
  // video
  ////////////////////////////////////////

  // hsync countdown counter
  typedef logic [2:0] hs_count_t;

  // reload value on an hsync rising edge
  // keeps hsync clear of the vsync pulse
  localparam hs_count_t hs_delay_cycles = 3'd7;

  ////////////////////////////////////////
  // controller key word
  ////////////////////////////////////////

  // first field is the msb, dpad_up lands on bit 0
  typedef struct packed {
    logic face_start;
    logic face_select;
    logic trig_r3;
    logic trig_l3;
    logic trig_r2;
    logic trig_l2;
    logic trig_r1;
    logic trig_l1;
    logic face_y;
    logic face_x;
    logic face_b;
    logic face_a;
    logic dpad_right;
    logic dpad_left;
    logic dpad_down;
    logic dpad_up;
  } pocket_key_s;

  // same 16 bits, raw bitmap or named buttons
  typedef union packed {
    logic [key_w-1:0] raw;
    pocket_key_s      btn;
  } pocket_key_u;

endpackage

//--- rtl/nes_video_if.sv
// raw video from the emulator: blanks, syncs and colour
// source side is the top level, sink side the shaper

`timescale 1ns/1ps

interface nes_video_if;

  // blank levels, high outside the active area
  logic                     h_blank;
  logic                     v_blank;

  // sync levels straight from the ppu
  logic                     hs;
  logic                     vs;

  // packed colour, r g b from msb
  logic [core_pkg::rgb_w-1:0] rgb;

  // driver side
  modport source (output h_blank, v_blank, hs, vs, rgb);

  // consumer side
  modport sink (input h_blank, v_blank, hs, vs, rgb);

endinterface

//--- rtl/video_sync_shaper.sv
// video conditioning for the scaler
// data enable from blanks, colour gated while blanked
// vsync rising edge to one-cycle pulse, hsync pulse delayed

`timescale 1ns/1ps

module video_sync_shaper (
  input  logic                       clk_74a,
  input  logic                       reset,
  nes_video_if.sink                  vid_in,
  output logic                       video_de,
  output logic                       video_hs,
  output logic                       video_vs,
  output logic [core_pkg::rgb_w-1:0] video_rgb
);

  ////////////////////////////////////////
  // edge detect
  ////////////////////////////////////////

  // previous sync samples
  logic hs_prev;
  logic vs_prev;

  // active pixel this cycle
  logic de_next;

  // rising edges seen on this sample
  logic hs_rise;
  logic vs_rise;

  // hsync delay countdown
  core_pkg::hs_count_t hs_count;

  assign de_next = ~(vid_in.h_blank | vid_in.v_blank);
  assign hs_rise = vid_in.hs & ~hs_prev;
  assign vs_rise = vid_in.vs & ~vs_prev;

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      // low so a sync already high counts as an edge
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
    end else begin
      hs_prev <= vid_in.hs;
      vs_prev <= vid_in.vs;
    end
  end

  ////////////////////////////////////////
  // data enable and colour
  ////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      video_de  <= 1'b0;
      video_rgb <= '0;
    end else begin
      video_de  <= de_next;
      // black outside the active area
      video_rgb <= de_next ? vid_in.rgb : '0;
    end
  end

  ////////////////////////////////////////
  // sync pulses
  ////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      hs_count <= '0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
    end else begin
      // one cycle, right after the rising edge
      video_vs <= vs_rise;

      // fires on the last count, seven edges after the load
      video_hs <= (hs_count == core_pkg::hs_count_t'(1));

      // new edge restarts the countdown
      if (hs_rise) begin
        hs_count <= core_pkg::hs_delay_cycles;
      end else if (hs_count != '0) begin
        hs_count <= hs_count - 1'b1;
      end
    end
  end

endmodule

//--- rtl/core_bridge_regs.sv
// configuration and status block beside the video path
// download level from the data-slot strobes
// controller 1 key remap into the nes button byte
// bridge read mux with the command region status word

`timescale 1ns/1ps

module core_bridge_regs (
  input  logic                           clk_74a,
  input  logic                           reset,
  input  logic                           dataslot_requestwrite,
  input  logic                           dataslot_allcomplete,
  input  logic [core_pkg::key_w-1:0]     cont1_key,
  input  logic [core_pkg::bridge_w-1:0]  bridge_addr,
  input  logic                           bridge_rd,
  output logic                           ioctl_download,
  output logic [core_pkg::nes_btn_w-1:0] nes_buttons,
  output logic [core_pkg::bridge_w-1:0]  bridge_rd_data
);

  ////////////////////////////////////////
  // download flag
  ////////////////////////////////////////

  // requestwrite wins over allcomplete
  always_ff @(posedge clk_74a) begin
    if (reset) begin
      ioctl_download <= 1'b0;
    end else if (dataslot_requestwrite) begin
      ioctl_download <= 1'b1;
    end else if (dataslot_allcomplete) begin
      ioctl_download <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // button remap
  ////////////////////////////////////////

  core_pkg::pocket_key_u            key;
  logic [core_pkg::nes_btn_w-1:0]   btn_next;

  assign key.raw = cont1_key;

  // nes order, a b select start up down left right from bit 0
  assign btn_next = {key.btn.dpad_right, key.btn.dpad_left,
                     key.btn.dpad_down,  key.btn.dpad_up,
                     key.btn.face_start, key.btn.face_select,
                     key.btn.face_b,     key.btn.face_a};

  always_ff @(posedge clk_74a) begin
    if (reset) begin
      nes_buttons <= '0;
    end else begin
      nes_buttons <= btn_next;
    end
  end

  ////////////////////////////////////////
  // bridge read mux
  ////////////////////////////////////////

  logic [core_pkg::bridge_w-1:0] status_word;
  logic                          cmd_hit;

  // buttons low, download flag above, rest zero
  always_comb begin
    status_word = '0;
    status_word[core_pkg::nes_btn_w-1:0] = nes_buttons;
    status_word[core_pkg::status_dl_bit] = ioctl_download;
  end

  // region picked by the top address byte
  assign cmd_hit = (bridge_addr[core_pkg::bridge_w-1 -: $bits(core_pkg::bridge_region_cmd)]
                    == core_pkg::bridge_region_cmd);

  // holds between reads, unknown regions read as zero
  always_ff @(posedge clk_74a) begin
    if (reset) begin
      bridge_rd_data <= '0;
    end else if (bridge_rd) begin
      bridge_rd_data <= cmd_hit ? status_word : '0;
    end
  end

endmodule

//--- rtl/core_top.sv
// board-facing glue for the nes core
// raw emulator video through the shaper to the scaler
// bridge status registers and controller remap beside it
// everything on clk_74a, one pixel per clock

`timescale 1ns/1ps

module core_top (
  input  logic                           clk_74a,
  input  logic                           reset,

  // raw video from the emulator
  input  logic                           nes_h_blank,
  input  logic                           nes_v_blank,
  input  logic                           nes_hs,
  input  logic                           nes_vs,
  input  logic [core_pkg::rgb_w-1:0]     nes_rgb,

  // controller 1 key bitmap
  input  logic [core_pkg::key_w-1:0]     cont1_key,

  // data-slot strobes from the command handler
  input  logic                           dataslot_requestwrite,
  input  logic                           dataslot_allcomplete,

  // bridge read side
  input  logic [core_pkg::bridge_w-1:0]  bridge_addr,
  input  logic                           bridge_rd,

  // video to the scaler
  output logic                           video_de,
  output logic                           video_hs,
  output logic                           video_vs,
  output logic [core_pkg::rgb_w-1:0]     video_rgb,

  // status and controls toward the emulator
  output logic                           ioctl_download,
  output logic [core_pkg::nes_btn_w-1:0] nes_buttons,
  output logic [core_pkg::bridge_w-1:0]  bridge_rd_data
);

  ////////////////////////////////////////
  // video path
  ////////////////////////////////////////

  nes_video_if u_vid ();

  // source side, fed straight from the pins
  assign u_vid.h_blank = nes_h_blank;
  assign u_vid.v_blank = nes_v_blank;
  assign u_vid.hs      = nes_hs;
  assign u_vid.vs      = nes_vs;
  assign u_vid.rgb     = nes_rgb;

  video_sync_shaper u_video (
    .clk_74a   (clk_74a),
    .reset     (reset),
    .vid_in    (u_vid.sink),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs),
    .video_rgb (video_rgb)
  );

  ////////////////////////////////////////
  // status registers
  ////////////////////////////////////////

  core_bridge_regs u_regs (
    .clk_74a               (clk_74a),
    .reset                 (reset),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .cont1_key             (cont1_key),
    .bridge_addr           (bridge_addr),
    .bridge_rd             (bridge_rd),
    .ioctl_download        (ioctl_download),
    .nes_buttons           (nes_buttons),
    .bridge_rd_data        (bridge_rd_data)
  );

endmodule

//--- testbench/core_top_assert.sv
// bound checks on the core glue outputs
// one-cycle sync pulses, colour gating, reset state

`timescale 1ns/1ps

module core_top_assert (
  input logic        clk_74a,
  input logic        reset,
  input logic        video_de,
  input logic        video_hs,
  input logic        video_vs,
  input logic [23:0] video_rgb,
  input logic        ioctl_download,
  input logic [7:0]  nes_buttons,
  input logic [31:0] bridge_rd_data
);

  // sync pulses last a single cycle
  assert property (@(posedge clk_74a) disable iff (reset) video_vs |=> !video_vs)
    else $error("video_vs stayed high for two cycles");
  assert property (@(posedge clk_74a) disable iff (reset) video_hs |=> !video_hs)
    else $error("video_hs stayed high for two cycles");

  // black outside the active area
  assert property (@(posedge clk_74a) !video_de |-> video_rgb == '0)
    else $error("video_rgb not zero while data enable is low");

  // outputs still at reset values on the first cycle out of reset
  assert property (@(posedge clk_74a) ($past(reset) && !reset) |->
                   (!video_de && !video_hs && !video_vs && video_rgb == '0 &&
                    !ioctl_download && nes_buttons == '0 && bridge_rd_data == '0))
    else $error("outputs not zero on the first cycle after reset");

endmodule

bind core_top core_top_assert u_assert (
  .clk_74a        (clk_74a),
  .reset          (reset),
  .video_de       (video_de),
  .video_hs       (video_hs),
  .video_vs       (video_vs),
  .video_rgb      (video_rgb),
  .ioctl_download (ioctl_download),
  .nes_buttons    (nes_buttons),
  .bridge_rd_data (bridge_rd_data)
);

//--- testbench/tb_core_top.sv
// testbench for the core glue top level
// stimulus table with predicted outputs, applied on falling edges
// reference model built from the timing rules of each block

`timescale 1ns/1ps

module tb_core_top;

  typedef struct packed {
    logic        h_blank;
    logic        v_blank;
    logic        hs;
    logic        vs;
    logic [23:0] rgb;
    logic [15:0] key;
    logic        req;
    logic        done;
    logic        rd;
    logic [31:0] addr;
    logic        exp_de;
    logic        exp_hs;
    logic        exp_vs;
    logic [23:0] exp_rgb;
    logic        exp_dl;
    logic [7:0]  exp_btn;
    logic [31:0] exp_rd;
  } row_t;

  // starts low before any process runs, so the first edge seen is a real one
  logic        clk_74a = 1'b0;
  logic        reset;
  logic        nes_h_blank;
  logic        nes_v_blank;
  logic        nes_hs;
  logic        nes_vs;
  logic [23:0] nes_rgb;
  logic [15:0] cont1_key;
  logic        dataslot_requestwrite;
  logic        dataslot_allcomplete;
  logic [31:0] bridge_addr;
  logic        bridge_rd;
  logic        video_de;
  logic        video_hs;
  logic        video_vs;
  logic [23:0] video_rgb;
  logic        ioctl_download;
  logic [7:0]  nes_buttons;
  logic [31:0] bridge_rd_data;

  row_t        rows[$];
  logic [31:0] rng_state = 32'h2885_16d2;
  int          checks = 0;
  int          errors = 0;

  core_top i_dut (
    .clk_74a               (clk_74a),
    .reset                 (reset),
    .nes_h_blank           (nes_h_blank),
    .nes_v_blank           (nes_v_blank),
    .nes_hs                (nes_hs),
    .nes_vs                (nes_vs),
    .nes_rgb               (nes_rgb),
    .cont1_key             (cont1_key),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .bridge_addr           (bridge_addr),
    .bridge_rd             (bridge_rd),
    .video_de              (video_de),
    .video_hs              (video_hs),
    .video_vs              (video_vs),
    .video_rgb             (video_rgb),
    .ioctl_download        (ioctl_download),
    .nes_buttons           (nes_buttons),
    .bridge_rd_data        (bridge_rd_data)
  );

  // 8 ns period
  initial begin
    forever #4 clk_74a = ~clk_74a;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // lcg, numerical recipes constants
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic void add_row(logic hb, logic vb, logic hs, logic vs, logic [23:0] rgb,
                                  logic [15:0] key, logic req, logic done, logic rd,
                                  logic [31:0] addr);
    row_t r;
    r = '0;
    r.h_blank = hb;
    r.v_blank = vb;
    r.hs      = hs;
    r.vs      = vs;
    r.rgb     = rgb;
    r.key     = key;
    r.req     = req;
    r.done    = done;
    r.rd      = rd;
    r.addr    = addr;
    rows.push_back(r);
  endfunction

  task automatic build_table();
    logic [31:0] r;
    logic [31:0] c;
    logic [7:0]  top;
    int          j;
    // blank gating with random colour
    for (j = 0; j < 16; j++) begin
      r = next_random();
      c = next_random();
      add_row(r[0], r[1] & r[2], 1'b0, 1'b0, c[23:0], 16'h0, 1'b0, 1'b0, 1'b0, 32'h0);
    end
    // vsync level held high, then low
    for (j = 0; j < 14; j++) begin
      add_row(1'b0, 1'b0, 1'b0, j < 10, 24'h0, 16'h0, 1'b0, 1'b0, 1'b0, 32'h0);
    end
    // hsync rise, restart inside the countdown, then a lone pulse
    for (j = 0; j < 30; j++) begin
      add_row(1'b0, 1'b0, j < 2 || j == 5 || j == 18, 1'b0, 24'h0, 16'h0,
              1'b0, 1'b0, 1'b0, 32'h0);
    end
    // download flag, idle gaps and a collision
    for (j = 0; j < 12; j++) begin
      add_row(1'b1, 1'b0, 1'b0, 1'b0, 24'h0, 16'h0, j == 0 || j == 7, j == 4 || j == 7,
              1'b0, 32'h0);
    end
    // random keys with reads in and out of the command region
    for (j = 0; j < 24; j++) begin
      r   = next_random();
      c   = next_random();
      top = (c[31:24] == core_pkg::bridge_region_cmd) ? 8'hF7 : c[31:24];
      add_row(1'b0, 1'b1, 1'b0, 1'b0, 24'h0, r[15:0], j == 0, j == 14, j[0],
              {j[1] ? core_pkg::bridge_region_cmd : top, c[23:0]});
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  task automatic predict_table();
    core_pkg::pocket_key_u k;
    logic        hs_p;
    logic        vs_p;
    logic        dl;
    logic [7:0]  btn;
    logic [31:0] rd_v;
    int          hs_since;
    int          i;
    hs_p     = 1'b0;
    vs_p     = 1'b0;
    dl       = 1'b0;
    btn      = '0;
    rd_v     = '0;
    // edges since the last hsync rise, -1 when idle
    hs_since = -1;
    for (i = 0; i < rows.size(); i++) begin
      // read sees the registers from before this edge
      if (rows[i].rd) begin
        rd_v = (rows[i].addr[31:24] == core_pkg::bridge_region_cmd) ? {23'd0, dl, btn} : '0;
      end
      rows[i].exp_rd = rd_v;
      if (rows[i].hs && !hs_p) begin
        hs_since = 0;
      end else if (hs_since >= 0 && hs_since < int'(core_pkg::hs_delay_cycles)) begin
        hs_since++;
      end else begin
        hs_since = -1;
      end
      rows[i].exp_hs  = (hs_since == int'(core_pkg::hs_delay_cycles));
      rows[i].exp_vs  = rows[i].vs && !vs_p;
      hs_p            = rows[i].hs;
      vs_p            = rows[i].vs;
      rows[i].exp_de  = !(rows[i].h_blank || rows[i].v_blank);
      rows[i].exp_rgb = rows[i].exp_de ? rows[i].rgb : '0;
      // requestwrite wins on a collision
      if (rows[i].req) begin
        dl = 1'b1;
      end else if (rows[i].done) begin
        dl = 1'b0;
      end
      rows[i].exp_dl  = dl;
      // nes byte, a b select start up down left right
      k.raw = rows[i].key;
      btn   = {k.btn.dpad_right, k.btn.dpad_left, k.btn.dpad_down, k.btn.dpad_up,
               k.btn.face_start, k.btn.face_select, k.btn.face_b, k.btn.face_a};
      rows[i].exp_btn = btn;
    end
  endtask

  ////////////////////////////////////////
  // drive and check
  ////////////////////////////////////////

  task automatic wait_fall();
    int n;
    bit seen;
    seen = 1'b0;
    for (n = 0; n < 4 && !seen; n++) begin
      @(clk_74a);
      seen = (clk_74a == 1'b0);
    end
    if (!seen) begin
      $display("timeout: no falling clock edge seen");
      $display("Simulation finished: FAIL");
      $finish;
    end
  endtask

  task automatic drive_row(int i);
    nes_h_blank           = rows[i].h_blank;
    nes_v_blank           = rows[i].v_blank;
    nes_hs                = rows[i].hs;
    nes_vs                = rows[i].vs;
    nes_rgb               = rows[i].rgb;
    cont1_key             = rows[i].key;
    dataslot_requestwrite = rows[i].req;
    dataslot_allcomplete  = rows[i].done;
    bridge_rd             = rows[i].rd;
    bridge_addr           = rows[i].addr;
  endtask

  task automatic check_value(string name, int row, logic [31:0] actual, logic [31:0] expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED row %0d %s expected %h actual %h", row, name, expected, actual);
    end
  endtask

  task automatic check_row(int i);
    check_value("video_de", i, 32'(video_de), 32'(rows[i].exp_de));
    check_value("video_hs", i, 32'(video_hs), 32'(rows[i].exp_hs));
    check_value("video_vs", i, 32'(video_vs), 32'(rows[i].exp_vs));
    check_value("video_rgb", i, 32'(video_rgb), 32'(rows[i].exp_rgb));
    check_value("ioctl_download", i, 32'(ioctl_download), 32'(rows[i].exp_dl));
    check_value("nes_buttons", i, 32'(nes_buttons), 32'(rows[i].exp_btn));
    check_value("bridge_rd_data", i, bridge_rd_data, rows[i].exp_rd);
  endtask

  initial begin
    int i;
    reset                 = 1'b1;
    nes_h_blank           = 1'b0;
    nes_v_blank           = 1'b0;
    nes_hs                = 1'b0;
    nes_vs                = 1'b0;
    nes_rgb               = '0;
    cont1_key             = '0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    bridge_addr           = '0;
    bridge_rd             = 1'b0;
    build_table();
    predict_table();
    // five reset cycles
    for (i = 0; i < 5; i++) begin
      wait_fall();
    end
    reset = 1'b0;
    // each row is checked on the falling edge after its rising edge
    for (i = 0; i < rows.size(); i++) begin
      if (i > 0) begin
        wait_fall();
        check_row(i - 1);
      end
      drive_row(i);
    end
    wait_fall();
    check_row(rows.size() - 1);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
rtl/core_pkg.sv
rtl/nes_video_if.sv
rtl/video_sync_shaper.sv
rtl/core_bridge_regs.sv
rtl/core_top.sv
testbench/core_top_assert.sv
testbench/tb_core_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core glue testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core_top -f tb.f \
  || { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/Vtb_core_top)"
echo "$out"

echo "$out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1
